/* rtl/csr_macros.svh */
// Widths, reset values and bit positions shared by the CSR file.
// Only RV64 is supported, so the mstatus layout assumes a 64-bit word.
// mip bit positions follow the machine-level interrupt numbering.
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

`define CSR_XLEN        64
`define CSR_ADDR_W      12
`define CSR_CAUSE_W     5
`define CSR_COMMIT_W    3

// mtvec value out of reset
`define CSR_BOOT_ADDR   64'h0000_0000_8000_0000

// machine interrupt bit positions in mie and mip
`define CSR_IRQ_M_SOFT  3
`define CSR_IRQ_M_TIMER 7
`define CSR_IRQ_M_EXT   11

`define CSR_MIE_MASK    ((64'd1 << `CSR_IRQ_M_SOFT) | (64'd1 << `CSR_IRQ_M_TIMER) | \
                         (64'd1 << `CSR_IRQ_M_EXT))

// MXL = 2 (64-bit), extensions I and M
`define CSR_MISA_VAL    64'h8000_0000_0000_1100

`endif

/* rtl/csr_pkg.sv */
// Types shared by the CSR file: privilege levels, CSR addresses and mstatus.
// Supervisor mode is not implemented, so only USER and MACHINE exist.
`include "csr_macros.svh"

package csr_pkg;

  typedef enum logic [1:0] {
    USER    = 2'b00,
    MACHINE = 2'b11
  } privilege_e;

  typedef enum logic [`CSR_ADDR_W-1:0] {
    CSR_MSTATUS   = 12'h300,
    CSR_MISA      = 12'h301,
    CSR_MIE       = 12'h304,
    CSR_MTVEC     = 12'h305,
    CSR_MSCRATCH  = 12'h340,
    CSR_MEPC      = 12'h341,
    CSR_MCAUSE    = 12'h342,
    CSR_MIP       = 12'h344,
    CSR_MCYCLE    = 12'hb00,
    CSR_MINSTRET  = 12'hb02,
    CSR_CYCLE     = 12'hc00,
    CSR_INSTRET   = 12'hc02,
    CSR_MVENDORID = 12'hf11,
    CSR_MARCHID   = 12'hf12,
    CSR_MIMPID    = 12'hf13,
    CSR_MHARTID   = 12'hf14
  } csr_addr_e;

  // RV64 mstatus, msb first
  typedef struct packed {
    logic [27:0] rsvd_63_36;
    logic [1:0]  sxl;
    logic [1:0]  uxl;
    logic [18:0] rsvd_31_13;
    privilege_e  mpp;
    logic [2:0]  rsvd_10_8;
    logic        mpie;
    logic [2:0]  rsvd_6_4;
    logic        mie;
    logic [2:0]  rsvd_2_0;
  } mstatus_fields_t;

  // raw view for csr writes and reads, field view for trap bookkeeping
  typedef union packed {
    logic [`CSR_XLEN-1:0] raw;
    mstatus_fields_t      fields;
  } mstatus_u;

endpackage

/* rtl/csr_commit_buffer.sv */
// Holds one pending CSR write until its instruction commits or is flushed.
// The commit strobe is combinational so the write lands on the commit edge.
`timescale 1ns/100ps
`include "csr_macros.svh"

module csr_commit_buffer (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 flush_i,
  input  logic                 commit_i,
  input  logic                 wr_en_i,
  input  csr_pkg::csr_addr_e   wr_addr_i,
  input  logic [`CSR_XLEN-1:0] wr_data_i,
  output csr_pkg::csr_addr_e   wr_addr_o,
  output logic [`CSR_XLEN-1:0] wr_data_o,
  output logic                 wr_commit_o
);

  csr_pkg::csr_addr_e   addr_q;
  logic [`CSR_XLEN-1:0] data_q;
  logic                 valid_q;

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      addr_q <= wr_addr_i;
      data_q <= wr_data_i;
    end
  end

  // flush squashes the instruction even if it writes this cycle
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (wr_en_i) begin
      valid_q <= 1'b1;
    end else if (commit_i) begin
      valid_q <= 1'b0;
    end
  end

  assign wr_addr_o   = addr_q;
  assign wr_data_o   = data_q;
  assign wr_commit_o = commit_i & valid_q;

endmodule

/* rtl/csr_trap_ctrl.sv */
// Privilege level, mstatus, mepc and mcause with trap entry and mret.
// A committed CSR write wins over trap bookkeeping on the same register.
// mstatus writes are taken as given; software must keep mpp at USER or MACHINE.
`timescale 1ns/100ps
`include "csr_macros.svh"

module csr_trap_ctrl (
  input  logic                     clk,
  input  logic                     reset,
  input  csr_pkg::csr_addr_e       wr_addr_i,
  input  logic [`CSR_XLEN-1:0]     wr_data_i,
  input  logic                     wr_commit_i,
  input  logic                     exception_i,
  input  logic [`CSR_XLEN-1:0]     exception_pc_i,
  input  logic [`CSR_CAUSE_W-1:0]  exception_cause_i,
  input  logic                     mret_i,
  input  logic [`CSR_XLEN-1:0]     mie_i,
  input  logic [`CSR_XLEN-1:0]     mip_i,
  output csr_pkg::mstatus_u        mstatus_o,
  output logic [`CSR_XLEN-1:0]     mepc_o,
  output logic [`CSR_XLEN-1:0]     mcause_o,
  output csr_pkg::privilege_e      priv_o,
  output logic                     interrupt_pending_o
);

  // 64-bit encoding of sxl and uxl
  localparam logic [1:0] XL_64 = 2'b10;

  csr_pkg::mstatus_u    mstatus_q, mstatus_d;
  logic [`CSR_XLEN-1:0] mepc_q, mepc_d;
  logic [`CSR_XLEN-1:0] mcause_q, mcause_d;
  csr_pkg::privilege_e  priv_q, priv_d;
  logic                 irq_any;

  always_comb begin
    mstatus_d = mstatus_q;
    mepc_d    = mepc_q;
    mcause_d  = mcause_q;
    priv_d    = priv_q;

    if (exception_i) begin
      mepc_d                  = {exception_pc_i[`CSR_XLEN-1:1], 1'b0};
      mcause_d                = {{(`CSR_XLEN-`CSR_CAUSE_W){1'b0}}, exception_cause_i};
      mstatus_d.fields.mpie   = mstatus_q.fields.mie;
      mstatus_d.fields.mie    = 1'b0;
      mstatus_d.fields.mpp    = priv_q;
      priv_d                  = csr_pkg::MACHINE;
    end else if (mret_i) begin
      // restore the enable and drop back to the saved privilege
      mstatus_d.fields.mie    = mstatus_q.fields.mpie;
      mstatus_d.fields.mpie   = 1'b1;
      mstatus_d.fields.mpp    = csr_pkg::USER;
      priv_d                  = mstatus_q.fields.mpp;
    end

    if (wr_commit_i) begin
      case (wr_addr_i)
        csr_pkg::CSR_MSTATUS: mstatus_d.raw = wr_data_i;
        csr_pkg::CSR_MEPC:    mepc_d = {wr_data_i[`CSR_XLEN-1:1], 1'b0};
        csr_pkg::CSR_MCAUSE:  mcause_d = wr_data_i;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mstatus_q.raw <= {28'b0, XL_64, XL_64, 32'b0};
      mepc_q        <= '0;
      mcause_q      <= '0;
      priv_q        <= csr_pkg::MACHINE;
    end else begin
      mstatus_q <= mstatus_d;
      mepc_q    <= mepc_d;
      mcause_q  <= mcause_d;
      priv_q    <= priv_d;
    end
  end

  // user mode has no uie bit, so any enabled pending irq traps
  assign irq_any = |(mie_i & mip_i);
  assign interrupt_pending_o = irq_any &&
                               ((priv_q == csr_pkg::MACHINE && mstatus_q.fields.mie) ||
                                priv_q == csr_pkg::USER);

  assign mstatus_o = mstatus_q;
  assign mepc_o    = mepc_q;
  assign mcause_o  = mcause_q;
  assign priv_o    = priv_q;

endmodule

/* rtl/csr_machine_regs.sv */
// mie, mtvec and mscratch storage plus the live mip word.
// Only MSIE, MTIE and MEIE are writable in mie.
// mip has no writable bits; it follows the irq lines directly.
`timescale 1ns/100ps
`include "csr_macros.svh"

module csr_machine_regs (
  input  logic                 clk,
  input  logic                 reset,
  input  csr_pkg::csr_addr_e   wr_addr_i,
  input  logic [`CSR_XLEN-1:0] wr_data_i,
  input  logic                 wr_commit_i,
  input  logic                 irq_ext_i,
  input  logic                 irq_soft_i,
  input  logic                 irq_timer_i,
  output logic [`CSR_XLEN-1:0] mie_o,
  output logic [`CSR_XLEN-1:0] mip_o,
  output logic [`CSR_XLEN-1:0] mtvec_o,
  output logic [`CSR_XLEN-1:0] mscratch_o
);

  logic [`CSR_XLEN-1:0] mie_q;
  logic [`CSR_XLEN-1:0] mtvec_q;
  logic [`CSR_XLEN-1:0] mscratch_q;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mie_q      <= '0;
      mtvec_q    <= `CSR_BOOT_ADDR;
      mscratch_q <= '0;
    end else if (wr_commit_i) begin
      case (wr_addr_i)
        csr_pkg::CSR_MIE:      mie_q <= wr_data_i & `CSR_MIE_MASK;
        // mode field: bit 1 reserved, keeps direct/vectored in bit 0
        csr_pkg::CSR_MTVEC:    mtvec_q <= {wr_data_i[`CSR_XLEN-1:2], 1'b0, wr_data_i[0]};
        csr_pkg::CSR_MSCRATCH: mscratch_q <= wr_data_i;
        default: ;
      endcase
    end
  end

  always_comb begin
    mip_o                   = '0;
    mip_o[`CSR_IRQ_M_SOFT]  = irq_soft_i;
    mip_o[`CSR_IRQ_M_TIMER] = irq_timer_i;
    mip_o[`CSR_IRQ_M_EXT]   = irq_ext_i;
  end

  assign mie_o      = mie_q;
  assign mtvec_o    = mtvec_q;
  assign mscratch_o = mscratch_q;

endmodule

/* rtl/csr_counters.sv */
// Free-running mcycle and commit-driven minstret.
// A committed write to a counter replaces that cycle's increment.
`timescale 1ns/100ps
`include "csr_macros.svh"

module csr_counters (
  input  logic                     clk,
  input  logic                     reset,
  input  csr_pkg::csr_addr_e       wr_addr_i,
  input  logic [`CSR_XLEN-1:0]     wr_data_i,
  input  logic                     wr_commit_i,
  input  logic [`CSR_COMMIT_W-1:0] commit_count_i,
  output logic [`CSR_XLEN-1:0]     mcycle_o,
  output logic [`CSR_XLEN-1:0]     minstret_o
);

  logic [`CSR_XLEN-1:0] mcycle_q;
  logic [`CSR_XLEN-1:0] minstret_q;
  logic                 wr_mcycle;
  logic                 wr_minstret;

  assign wr_mcycle   = wr_commit_i && (wr_addr_i == csr_pkg::CSR_MCYCLE);
  assign wr_minstret = wr_commit_i && (wr_addr_i == csr_pkg::CSR_MINSTRET);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mcycle_q   <= '0;
      minstret_q <= '0;
    end else begin
      mcycle_q   <= wr_mcycle ? wr_data_i : mcycle_q + 1'b1;
      // commit_count_i is the number of instructions retiring this cycle
      minstret_q <= wr_minstret ? wr_data_i :
                    minstret_q + {{(`CSR_XLEN-`CSR_COMMIT_W){1'b0}}, commit_count_i};
    end
  end

  assign mcycle_o   = mcycle_q;
  assign minstret_o = minstret_q;

endmodule

/* rtl/csr_read_port.sv */
// Combinational CSR read plus the read checkpoint for the atomicity check.
// The same decode serves the read address and the checkpointed address.
// Unknown addresses read as zero, never as an illegal-access trap.
`timescale 1ns/100ps
`include "csr_macros.svh"

module csr_read_port (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 flush_i,
  input  logic                 commit_i,
  input  logic                 rd_en_i,
  input  csr_pkg::csr_addr_e   rd_addr_i,
  input  logic [`CSR_XLEN-1:0] hart_id_i,
  input  csr_pkg::mstatus_u    mstatus_i,
  input  logic [`CSR_XLEN-1:0] mepc_i,
  input  logic [`CSR_XLEN-1:0] mcause_i,
  input  logic [`CSR_XLEN-1:0] mie_i,
  input  logic [`CSR_XLEN-1:0] mip_i,
  input  logic [`CSR_XLEN-1:0] mtvec_i,
  input  logic [`CSR_XLEN-1:0] mscratch_i,
  input  logic [`CSR_XLEN-1:0] mcycle_i,
  input  logic [`CSR_XLEN-1:0] minstret_i,
  output logic [`CSR_XLEN-1:0] rd_data_o,
  output logic                 atomic_vio_o
);

  csr_pkg::csr_addr_e   chk_addr_q;
  logic [`CSR_XLEN-1:0] chk_data_q;
  logic                 chk_valid_q;
  logic [`CSR_XLEN-1:0] chk_live;

  function automatic logic [`CSR_XLEN-1:0] csr_value(input csr_pkg::csr_addr_e addr);
    logic [`CSR_XLEN-1:0] value;
    value = '0;
    case (addr)
      csr_pkg::CSR_MSTATUS:  value = mstatus_i.raw;
      csr_pkg::CSR_MISA:     value = `CSR_MISA_VAL;
      csr_pkg::CSR_MIE:      value = mie_i;
      csr_pkg::CSR_MTVEC:    value = mtvec_i;
      csr_pkg::CSR_MSCRATCH: value = mscratch_i;
      csr_pkg::CSR_MEPC:     value = mepc_i;
      csr_pkg::CSR_MCAUSE:   value = mcause_i;
      csr_pkg::CSR_MIP:      value = mip_i;
      // user counters are read-only aliases of the machine ones
      csr_pkg::CSR_MCYCLE,
      csr_pkg::CSR_CYCLE:    value = mcycle_i;
      csr_pkg::CSR_MINSTRET,
      csr_pkg::CSR_INSTRET:  value = minstret_i;
      csr_pkg::CSR_MHARTID:  value = hart_id_i;
      // no vendor, architecture or implementation id
      csr_pkg::CSR_MVENDORID,
      csr_pkg::CSR_MARCHID,
      csr_pkg::CSR_MIMPID:   value = '0;
      default:               value = '0;
    endcase
    return value;
  endfunction

  assign rd_data_o = csr_value(rd_addr_i);
  assign chk_live  = csr_value(chk_addr_q);

  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      chk_addr_q <= rd_addr_i;
      chk_data_q <= rd_data_o;
    end
  end

  // checkpoint lives until the reading instruction retires or is squashed
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      chk_valid_q <= 1'b0;
    end else if (rd_en_i) begin
      chk_valid_q <= 1'b1;
    end else if (commit_i || flush_i) begin
      chk_valid_q <= 1'b0;
    end
  end

  assign atomic_vio_o = chk_valid_q && (chk_live != chk_data_q);

endmodule

/* rtl/csr_file_top.sv */
// Machine-mode CSR file sitting beside the commit stage.
// Writes are deferred until commit; flush discards a pending write.
// At most one CSR instruction is in flight at a time.
// The current privilege has no consumer outside the trap logic.
`timescale 1ns/100ps
`include "csr_macros.svh"

module csr_file_top (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       flush_i,
  input  logic                       wr_en_i,
  input  csr_pkg::csr_addr_e         wr_addr_i,
  input  logic [`CSR_XLEN-1:0]       wr_data_i,
  input  logic                       commit_i,
  input  logic                       rd_en_i,
  input  csr_pkg::csr_addr_e         rd_addr_i,
  input  logic [`CSR_COMMIT_W-1:0]   commit_count_i,
  input  logic                       exception_i,
  input  logic [`CSR_XLEN-1:0]       exception_pc_i,
  input  logic [`CSR_CAUSE_W-1:0]    exception_cause_i,
  input  logic                       mret_i,
  input  logic                       irq_ext_i,
  input  logic                       irq_soft_i,
  input  logic                       irq_timer_i,
  input  logic [`CSR_XLEN-1:0]       hart_id_i,
  output logic [`CSR_XLEN-1:0]       rd_data_o,
  output logic                       atomic_vio_o,
  output logic                       interrupt_pending_o,
  output logic [`CSR_XLEN-1:0]       epc_o,
  output logic [`CSR_XLEN-1:0]       evec_o
);

  csr_pkg::csr_addr_e   wr_addr;
  logic [`CSR_XLEN-1:0] wr_data;
  logic                 wr_commit;
  csr_pkg::mstatus_u    mstatus;
  logic [`CSR_XLEN-1:0] mcause;
  logic [`CSR_XLEN-1:0] mie;
  logic [`CSR_XLEN-1:0] mip;
  logic [`CSR_XLEN-1:0] mscratch;
  logic [`CSR_XLEN-1:0] mcycle;
  logic [`CSR_XLEN-1:0] minstret;

  csr_commit_buffer commit_buffer_i (
    .clk         (clk),
    .reset       (reset),
    .flush_i     (flush_i),
    .commit_i    (commit_i),
    .wr_en_i     (wr_en_i),
    .wr_addr_i   (wr_addr_i),
    .wr_data_i   (wr_data_i),
    .wr_addr_o   (wr_addr),
    .wr_data_o   (wr_data),
    .wr_commit_o (wr_commit)
  );

  // mepc and mtvec drive epc_o and evec_o directly
  csr_trap_ctrl trap_ctrl_i (
    .clk                 (clk),
    .reset               (reset),
    .wr_addr_i           (wr_addr),
    .wr_data_i           (wr_data),
    .wr_commit_i         (wr_commit),
    .exception_i         (exception_i),
    .exception_pc_i      (exception_pc_i),
    .exception_cause_i   (exception_cause_i),
    .mret_i              (mret_i),
    .mie_i               (mie),
    .mip_i               (mip),
    .mstatus_o           (mstatus),
    .mepc_o              (epc_o),
    .mcause_o            (mcause),
    .priv_o              (),
    .interrupt_pending_o (interrupt_pending_o)
  );

  csr_machine_regs machine_regs_i (
    .clk         (clk),
    .reset       (reset),
    .wr_addr_i   (wr_addr),
    .wr_data_i   (wr_data),
    .wr_commit_i (wr_commit),
    .irq_ext_i   (irq_ext_i),
    .irq_soft_i  (irq_soft_i),
    .irq_timer_i (irq_timer_i),
    .mie_o       (mie),
    .mip_o       (mip),
    .mtvec_o     (evec_o),
    .mscratch_o  (mscratch)
  );

  csr_counters counters_i (
    .clk            (clk),
    .reset          (reset),
    .wr_addr_i      (wr_addr),
    .wr_data_i      (wr_data),
    .wr_commit_i    (wr_commit),
    .commit_count_i (commit_count_i),
    .mcycle_o       (mcycle),
    .minstret_o     (minstret)
  );

  csr_read_port read_port_i (
    .clk          (clk),
    .reset        (reset),
    .flush_i      (flush_i),
    .commit_i     (commit_i),
    .rd_en_i      (rd_en_i),
    .rd_addr_i    (rd_addr_i),
    .hart_id_i    (hart_id_i),
    .mstatus_i    (mstatus),
    .mepc_i       (epc_o),
    .mcause_i     (mcause),
    .mie_i        (mie),
    .mip_i        (mip),
    .mtvec_i      (evec_o),
    .mscratch_i   (mscratch),
    .mcycle_i     (mcycle),
    .minstret_i   (minstret),
    .rd_data_o    (rd_data_o),
    .atomic_vio_o (atomic_vio_o)
  );

endmodule

/* verification/csr_file_tb.sv */
// Directed testbench for the machine-mode CSR file.
// Inputs change on the rising edge and outputs are sampled on the falling edge.
// Tests run in order and share state; the interrupt test leaves the core in USER.
`timescale 1ns/100ps
`include "csr_macros.svh"

module csr_file_tb;

  // mstatus bit positions from the privileged spec
  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_MPIE = 7;
  localparam int MSTATUS_MPP  = 11;
  localparam int WAIT_LIMIT   = 20;

  logic                       clk;
  logic                       reset;
  logic                       flush_i;
  logic                       wr_en_i;
  csr_pkg::csr_addr_e         wr_addr_i;
  logic [`CSR_XLEN-1:0]       wr_data_i;
  logic                       commit_i;
  logic                       rd_en_i;
  csr_pkg::csr_addr_e         rd_addr_i;
  logic [`CSR_COMMIT_W-1:0]   commit_count_i;
  logic                       exception_i;
  logic [`CSR_XLEN-1:0]       exception_pc_i;
  logic [`CSR_CAUSE_W-1:0]    exception_cause_i;
  logic                       mret_i;
  logic                       irq_ext_i;
  logic                       irq_soft_i;
  logic                       irq_timer_i;
  logic [`CSR_XLEN-1:0]       hart_id_i;
  logic [`CSR_XLEN-1:0]       rd_data_o;
  logic                       atomic_vio_o;
  logic                       interrupt_pending_o;
  logic [`CSR_XLEN-1:0]       epc_o;
  logic [`CSR_XLEN-1:0]       evec_o;

  int    errors = 0;
  int    test_errors = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  string cur_test = "reset";

  csr_file_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic note_error();
    errors++;
    test_errors++;
  endtask

  // a retired or squashed reader releases its checkpoint
  release_chk: assert property (@(posedge clk) disable iff (reset)
    (commit_i || flush_i) && !rd_en_i |=> !atomic_vio_o)
    else begin
      $display("test %s: atomic_vio_o stayed high after commit or flush", cur_test);
      note_error();
    end

  // no pending interrupt without at least one irq line up
  irq_source: assert property (@(posedge clk) disable iff (reset)
    interrupt_pending_o |-> (irq_ext_i || irq_soft_i || irq_timer_i))
    else begin
      $display("test %s: interrupt pending with all irq lines low", cur_test);
      note_error();
    end

  function automatic logic [63:0] rand64();
    return {$urandom(), $urandom()};
  endfunction

  task automatic check_value(input logic [63:0] expected, input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("MISMATCH %s: expected %h, actual %h", cur_test, expected, actual);
      note_error();
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: FAIL with %0d errors", cur_test, test_errors);
    end
  endtask

  task automatic read_csr(input csr_pkg::csr_addr_e addr, output logic [63:0] data);
    @(posedge clk);
    rd_addr_i <= addr;
    @(negedge clk);
    data = rd_data_o;
  endtask

  task automatic stage_write(input csr_pkg::csr_addr_e addr, input logic [63:0] data);
    @(posedge clk);
    wr_en_i   <= 1'b1;
    wr_addr_i <= addr;
    wr_data_i <= data;
    @(posedge clk);
    wr_en_i <= 1'b0;
  endtask

  task automatic pulse_commit();
    @(posedge clk);
    commit_i <= 1'b1;
    @(posedge clk);
    commit_i <= 1'b0;
  endtask

  task automatic pulse_flush();
    @(posedge clk);
    flush_i <= 1'b1;
    @(posedge clk);
    flush_i <= 1'b0;
  endtask

  task automatic pulse_mret();
    @(posedge clk);
    mret_i <= 1'b1;
    @(posedge clk);
    mret_i <= 1'b0;
  endtask

  task automatic write_csr(input csr_pkg::csr_addr_e addr, input logic [63:0] data);
    stage_write(addr, data);
    pulse_commit();
  endtask

  task automatic checkpoint(input csr_pkg::csr_addr_e addr);
    @(posedge clk);
    rd_addr_i <= addr;
    rd_en_i   <= 1'b1;
    @(posedge clk);
    rd_en_i <= 1'b0;
  endtask

  // use_irq picks interrupt_pending_o, otherwise atomic_vio_o
  task automatic wait_output(input bit use_irq, input logic level);
    int   n;
    logic seen;
    n = 0;
    @(negedge clk);
    seen = use_irq ? interrupt_pending_o : atomic_vio_o;
    while (seen !== level && n < WAIT_LIMIT) begin
      @(negedge clk);
      seen = use_irq ? interrupt_pending_o : atomic_vio_o;
      n++;
    end
    assert (seen === level) else begin
      $display("test %s: %s did not reach %b within %0d cycles", cur_test,
               use_irq ? "interrupt_pending_o" : "atomic_vio_o", level, WAIT_LIMIT);
      note_error();
    end
  endtask

  initial begin
    logic [63:0] old_val;
    logic [63:0] val;
    logic [63:0] data;
    logic [63:0] pc;
    logic [63:0] sum;
    logic [31:0] rnd;
    logic [4:0]  cause;
    int          n;

    void'($urandom(64310));
    reset = 1'b1;
    flush_i = 1'b0;
    wr_en_i = 1'b0;
    wr_addr_i = csr_pkg::CSR_MSCRATCH;
    wr_data_i = '0;
    commit_i = 1'b0;
    rd_en_i = 1'b0;
    rd_addr_i = csr_pkg::CSR_MSTATUS;
    commit_count_i = '0;
    exception_i = 1'b0;
    exception_pc_i = '0;
    exception_cause_i = '0;
    mret_i = 1'b0;
    irq_ext_i = 1'b0;
    irq_soft_i = 1'b0;
    irq_timer_i = 1'b0;
    hart_id_i = rand64();
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    begin_test("reset");
    @(negedge clk);
    check_value(64'd0, {63'd0, atomic_vio_o});
    check_value(64'd0, {63'd0, interrupt_pending_o});
    read_csr(csr_pkg::CSR_MTVEC, val);
    check_value(64'h8000_0000, val);
    // RV64 with I (bit 8) and M (bit 12)
    read_csr(csr_pkg::CSR_MISA, val);
    check_value((64'd2 << 62) | (64'd1 << 8) | (64'd1 << 12), val);
    read_csr(csr_pkg::CSR_MHARTID, val);
    check_value(hart_id_i, val);
    read_csr(csr_pkg::CSR_MVENDORID, val);
    check_value(64'd0, val);
    read_csr(csr_pkg::CSR_MSTATUS, val);
    check_value((64'd2 << 34) | (64'd2 << 32), val);
    end_test();

    begin_test("deferred_write");
    read_csr(csr_pkg::CSR_MSCRATCH, old_val);
    data = rand64();
    stage_write(csr_pkg::CSR_MSCRATCH, data);
    repeat (3) @(posedge clk);
    read_csr(csr_pkg::CSR_MSCRATCH, val);
    check_value(old_val, val);
    pulse_commit();
    @(negedge clk);
    check_value(data, rd_data_o);
    data = rand64() | 64'h2;
    write_csr(csr_pkg::CSR_MTVEC, data);
    read_csr(csr_pkg::CSR_MTVEC, val);
    check_value(data & ~64'h2, val);
    check_value(data & ~64'h2, evec_o);
    end_test();

    begin_test("flush");
    read_csr(csr_pkg::CSR_MSCRATCH, old_val);
    stage_write(csr_pkg::CSR_MSCRATCH, rand64());
    pulse_flush();
    pulse_commit();
    read_csr(csr_pkg::CSR_MSCRATCH, val);
    check_value(old_val, val);
    end_test();

    begin_test("counters");
    rnd = $urandom();
    n = 7 + int'(rnd[3:0]);
    read_csr(csr_pkg::CSR_MCYCLE, old_val);
    repeat (n) @(negedge clk);
    check_value(old_val + 64'(n), rd_data_o);
    read_csr(csr_pkg::CSR_MINSTRET, old_val);
    sum = '0;
    repeat (12) begin
      rnd = $urandom();
      @(posedge clk);
      commit_count_i <= rnd[2:0];
      sum += 64'(rnd[2:0]);
    end
    @(posedge clk);
    commit_count_i <= '0;
    @(negedge clk);
    check_value(old_val + sum, rd_data_o);
    // the count on the commit edge is replaced by the write
    data = rand64();
    stage_write(csr_pkg::CSR_MINSTRET, data);
    @(posedge clk);
    commit_i <= 1'b1;
    commit_count_i <= 3'd5;
    @(posedge clk);
    commit_i <= 1'b0;
    commit_count_i <= 3'd3;
    @(posedge clk);
    commit_count_i <= '0;
    read_csr(csr_pkg::CSR_INSTRET, val);
    check_value(data + 64'd3, val);
    end_test();

    begin_test("trap_mret");
    read_csr(csr_pkg::CSR_MSTATUS, val);
    write_csr(csr_pkg::CSR_MSTATUS, val | (64'd1 << MSTATUS_MIE));
    pc = rand64() | 64'd1;
    rnd = $urandom();
    cause = rnd[4:0];
    @(posedge clk);
    exception_i <= 1'b1;
    exception_pc_i <= pc;
    exception_cause_i <= cause;
    @(posedge clk);
    exception_i <= 1'b0;
    @(negedge clk);
    check_value(pc & ~64'd1, epc_o);
    read_csr(csr_pkg::CSR_MEPC, val);
    check_value(pc & ~64'd1, val);
    read_csr(csr_pkg::CSR_MCAUSE, val);
    check_value(64'(cause), val);
    read_csr(csr_pkg::CSR_MSTATUS, val);
    check_value(64'd0, 64'(val[MSTATUS_MIE]));
    check_value(64'd1, 64'(val[MSTATUS_MPIE]));
    check_value(64'd3, 64'(val[MSTATUS_MPP +: 2]));
    pulse_mret();
    read_csr(csr_pkg::CSR_MSTATUS, val);
    check_value(64'd1, 64'(val[MSTATUS_MIE]));
    check_value(64'd1, 64'(val[MSTATUS_MPIE]));
    check_value(64'd0, 64'(val[MSTATUS_MPP +: 2]));
    end_test();

    begin_test("interrupt");
    write_csr(csr_pkg::CSR_MIE, 64'd1 << `CSR_IRQ_M_TIMER);
    @(posedge clk);
    irq_timer_i <= 1'b1;
    wait_output(1'b1, 1'b1);
    read_csr(csr_pkg::CSR_MSTATUS, val);
    write_csr(csr_pkg::CSR_MSTATUS, val & ~(64'd1 << MSTATUS_MIE));
    wait_output(1'b1, 1'b0);
    // mpp is USER here, so mret drops the core to USER
    pulse_mret();
    wait_output(1'b1, 1'b1);
    read_csr(csr_pkg::CSR_MSTATUS, val);
    write_csr(csr_pkg::CSR_MSTATUS, val & ~(64'd1 << MSTATUS_MIE));
    @(negedge clk);
    check_value(64'd1, {63'd0, interrupt_pending_o});
    @(posedge clk);
    irq_timer_i <= 1'b0;
    irq_ext_i <= 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_value(64'd0, {63'd0, interrupt_pending_o});
    end
    @(posedge clk);
    irq_ext_i <= 1'b0;
    end_test();

    begin_test("atomicity");
    checkpoint(csr_pkg::CSR_MCYCLE);
    @(negedge clk);
    check_value(64'd1, {63'd0, atomic_vio_o});
    pulse_commit();
    @(negedge clk);
    check_value(64'd0, {63'd0, atomic_vio_o});
    checkpoint(csr_pkg::CSR_MSCRATCH);
    repeat (4) begin
      @(negedge clk);
      check_value(64'd0, {63'd0, atomic_vio_o});
    end
    pulse_flush();
    checkpoint(csr_pkg::CSR_MIP);
    @(posedge clk);
    irq_soft_i <= 1'b1;
    wait_output(1'b0, 1'b1);
    @(posedge clk);
    irq_soft_i <= 1'b0;
    pulse_flush();
    @(negedge clk);
    check_value(64'd0, {63'd0, atomic_vio_o});
    end_test();

    $display("summary: %0d tests, %0d with errors, %0d checks failed",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+rtl
rtl/csr_pkg.sv
rtl/csr_commit_buffer.sv
rtl/csr_trap_ctrl.sv
rtl/csr_machine_regs.sv
rtl/csr_counters.sv
rtl/csr_read_port.sv
rtl/csr_file_top.sv
verification/csr_file_tb.sv

/* Bender.yml */
package:
  name: csr_file

export_include_dirs:
  - rtl

sources:
  - rtl/csr_pkg.sv
  - rtl/csr_commit_buffer.sv
  - rtl/csr_trap_ctrl.sv
  - rtl/csr_machine_regs.sv
  - rtl/csr_counters.sv
  - rtl/csr_read_port.sv
  - rtl/csr_file_top.sv
  - target: simulation
    files:
      - verification/csr_file_tb.sv
